//--- source/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Bus widths
`define APB_ADDR_W      17
`define APB_DATA_W      32

// Address map
`define CSR_SEL_BIT     16      // 0 CSR bank, 1 timer
`define CSR_OP_LSB      14      // Two bits of operation code
`define CSR_NUM_LSB     2       // Twelve bits of CSR number

// Timer word offsets, taken from paddr[4:2]
`define TMR_MTIME_LO    3'd0
`define TMR_MTIME_HI    3'd1
`define TMR_MTCMP_LO    3'd2
`define TMR_MTCMP_HI    3'd3
`define TMR_MSIP        3'd4

// Writable bits per CSR
`define MASK_MSTATUS    32'h007E_19AA
`define MASK_MISA       32'h3C00_0000
`define MASK_MIE        32'h0000_0888
`define MASK_MTVEC      32'hFFFF_FFFC
`define MASK_MEPC       32'hFFFF_FFFC

`define MISA_RESET      32'h4000_0100   // RV32, I extension

`define CLINT_TICK_DIV  1               // Clocks per mtime step

`endif

//--- source/csr_pkg.sv
`include "csr_config.svh"

package csr_pkg;

    // Supported machine CSR numbers
    typedef enum logic [11:0] {
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        MVENDORID  = 12'hF11,
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15,
        CYCLE      = 12'hC00,
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        INSTRETH   = 12'hC82
    } csr_addr_e;

    typedef enum logic [1:0] {
        READ  = 2'd0,
        WRITE = 2'd1,
        SET   = 2'd2,
        CLEAR = 2'd3
    } csr_op_e;

    typedef enum logic [30:0] {
        ILLEGAL_INSTRUCTION = 31'd2,
        BREAKPOINT          = 31'd3,
        ECALL_FROM_MMODE    = 31'd11
    } except_code_e;

    typedef enum logic [30:0] {
        M_SW_INT  = 31'd3,
        M_TIM_INT = 31'd7,
        M_EXT_INT = 31'd11
    } irq_code_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

    // Sideband trap request from the core
    typedef struct packed {
        logic         raise_exception;
        logic         mret;
        except_code_e except_code;
        priv_e        privilege;
        logic [31:0]  pc;
        logic [31:0]  instruction;
    } trap_req_t;

    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic        interrupt;
            logic [30:0] code;
        } f;
    } mcause_u;

endpackage

//--- source/apb_arbiter.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module apb_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  csr_pkg::apb_req_t core_req,
    output csr_pkg::apb_rsp_t core_rsp,
    input  csr_pkg::apb_req_t dbg_req,
    output csr_pkg::apb_rsp_t dbg_rsp,
    output csr_pkg::apb_req_t bus_req,
    output logic              csr_psel,
    output logic              tmr_psel,
    input  csr_pkg::apb_rsp_t csr_rsp,
    input  csr_pkg::apb_rsp_t tmr_rsp
);
    import csr_pkg::*;

    logic     busy;         // Bus held until pready
    logic     owner;        // 0 core, 1 debug
    logic     last_win;     // Winner of the previous transfer
    logic     pick;
    logic     grant;
    logic     done;
    apb_req_t sel_req;
    apb_rsp_t slv_rsp;

    // Round-robin choice when both ask at once
    always_comb begin
        if (core_req.psel && dbg_req.psel)
            pick = ~last_win;
        else
            pick = dbg_req.psel;
    end

    assign grant   = busy ? owner : pick;
    assign sel_req = grant ? dbg_req : core_req;

    // A late grant gets a fresh setup cycle at the slave
    always_comb begin
        bus_req         = sel_req;
        bus_req.penable = sel_req.penable & busy;
    end

    assign csr_psel = bus_req.psel & ~bus_req.paddr[`CSR_SEL_BIT];
    assign tmr_psel = bus_req.psel & bus_req.paddr[`CSR_SEL_BIT];

    assign slv_rsp = bus_req.paddr[`CSR_SEL_BIT] ? tmr_rsp : csr_rsp;
    assign done    = busy & slv_rsp.pready;

    // Only the granted master sees the response
    always_comb begin
        core_rsp = '0;
        dbg_rsp  = '0;
        if (bus_req.psel) begin
            if (grant)
                dbg_rsp = slv_rsp;
            else
                core_rsp = slv_rsp;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            busy     <= 1'b0;
            owner    <= 1'b0;
            last_win <= 1'b1;   // Core wins the first tie
        end else if (done) begin
            busy     <= 1'b0;
            last_win <= owner;
        end else if (!busy && bus_req.psel) begin
            busy  <= 1'b1;
            owner <= grant;
        end
    end

endmodule

//--- source/csr_bank.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_bank (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::apb_req_t  bus_req,
    input  logic               psel,
    output csr_pkg::apb_rsp_t  rsp,
    input  csr_pkg::trap_req_t trap,
    input  logic               interrupt_ack,
    input  logic               retire,
    input  logic               ext_irq,
    input  logic               timer_irq,
    input  logic               sw_irq,
    output logic               interrupt_pending,
    output csr_pkg::irq_code_e irq_code,
    output logic [31:0]        mepc,
    output logic [31:0]        mtvec
);
    import csr_pkg::*;

    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LSB  = 11;

    logic [31:0] mstatus, misa, mie, mtvec_q, mscratch, mepc_q, mtval, mip;
    mcause_u     mcause;
    logic [63:0] cycle, instret;

    csr_op_e     op;
    csr_addr_e   csr_num;
    logic        access;
    logic        wr_intent;
    logic        trap_event;
    logic        do_write;
    logic        known;
    logic        writable;
    logic [31:0] current_val;
    logic [31:0] wmask;
    logic [31:0] new_val;
    logic [31:0] wr_data;

    assign op      = csr_op_e'(bus_req.paddr[`CSR_OP_LSB +: 2]);
    assign csr_num = csr_addr_e'(bus_req.paddr[`CSR_NUM_LSB +: 12]);

    assign access     = psel & bus_req.penable;
    assign wr_intent  = access & bus_req.pwrite & (op != READ);
    assign trap_event = trap.mret | trap.raise_exception | interrupt_ack;
    assign do_write   = wr_intent & known & writable & ~trap_event;

    always_comb begin
        known       = 1'b1;
        writable    = 1'b1;
        current_val = '0;
        wmask       = '0;
        case (csr_num)
            MSTATUS:  begin
                current_val = mstatus;
                wmask       = `MASK_MSTATUS;
            end
            MISA:     begin
                current_val = misa;
                wmask       = `MASK_MISA;
            end
            MIE:      begin
                current_val = mie;
                wmask       = `MASK_MIE;
            end
            MTVEC:    begin
                current_val = mtvec_q;
                wmask       = `MASK_MTVEC;     // Direct mode only
            end
            MSCRATCH: begin
                current_val = mscratch;
                wmask       = '1;
            end
            MEPC:     begin
                current_val = mepc_q;
                wmask       = `MASK_MEPC;
            end
            MCAUSE:   begin
                current_val = mcause.raw;
                wmask       = '1;
            end
            MTVAL:    begin
                current_val = mtval;
                wmask       = '1;
            end
            // Read-only group
            MIP:      begin
                current_val = mip;
                writable    = 1'b0;
            end
            MVENDORID, MARCHID, MIMPID, MHARTID, MCONFIGPTR: writable = 1'b0;
            CYCLE:    begin
                current_val = cycle[31:0];
                writable    = 1'b0;
            end
            CYCLEH:   begin
                current_val = cycle[63:32];
                writable    = 1'b0;
            end
            INSTRET:  begin
                current_val = instret[31:0];
                writable    = 1'b0;
            end
            INSTRETH: begin
                current_val = instret[63:32];
                writable    = 1'b0;
            end
            default:  begin
                known    = 1'b0;
                writable = 1'b0;
            end
        endcase
    end

    // Value before masking
    always_comb begin
        case (op)
            SET:     new_val = current_val | bus_req.pwdata;
            CLEAR:   new_val = current_val & ~bus_req.pwdata;
            default: new_val = bus_req.pwdata;
        endcase
    end

    assign wr_data = (current_val & ~wmask) | (new_val & wmask);  // Keep fixed bits

    // Old value comes back on every access
    assign rsp.prdata  = access ? current_val : '0;
    assign rsp.pready  = access;
    assign rsp.pslverr = access & (~known | (wr_intent & (~writable | trap_event)));

    assign mtvec = mtvec_q;
    assign mepc  = mepc_q;

    always_ff @(posedge clk) begin
        if (!reset) begin
            mstatus  <= '0;
            misa     <= `MISA_RESET;
            mie      <= '0;
            mtvec_q  <= '0;
            mscratch <= '0;
            mepc_q   <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (trap.mret) begin
            mstatus[MIE_BIT] <= mstatus[MPIE_BIT];
        end else if (trap.raise_exception) begin
            mcause.f.interrupt              <= 1'b0;
            mcause.f.code                   <= trap.except_code;
            mstatus[MPP_LSB +: 2]           <= trap.privilege;
            mstatus[MPIE_BIT]               <= mstatus[MIE_BIT];
            mstatus[MIE_BIT]                <= 1'b0;
            if (trap.except_code == ECALL_FROM_MMODE)
                mepc_q <= trap.pc;
            else
                mepc_q <= trap.pc + 32'd4;
            if (trap.except_code == ILLEGAL_INSTRUCTION)
                mtval <= trap.instruction;   // Faulting encoding
            else
                mtval <= trap.pc;
        end else if (interrupt_ack) begin
            mcause.f.interrupt    <= 1'b1;
            mcause.f.code         <= irq_code;
            mstatus[MPP_LSB +: 2] <= trap.privilege;
            mstatus[MPIE_BIT]     <= mstatus[MIE_BIT];
            mstatus[MIE_BIT]      <= 1'b0;
            mepc_q                <= trap.pc;   // Resume at interrupted instruction
        end else if (do_write) begin
            case (csr_num)
                MSTATUS:  mstatus    <= wr_data;
                MISA:     misa       <= wr_data;
                MIE:      mie        <= wr_data;
                MTVEC:    mtvec_q    <= wr_data;
                MSCRATCH: mscratch   <= wr_data;
                MEPC:     mepc_q     <= wr_data;
                MCAUSE:   mcause.raw <= wr_data;
                MTVAL:    mtval      <= wr_data;
                default:  ;
            endcase
        end
    end

    // Sample the interrupt lines into their standard positions
    always_ff @(posedge clk) begin
        if (!reset)
            mip <= '0;
        else
            mip <= {20'b0, ext_irq, 3'b0, timer_irq, 3'b0, sw_irq, 3'b0};
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            interrupt_pending <= 1'b0;
            irq_code          <= M_EXT_INT;
        end else begin
            interrupt_pending <= mstatus[MIE_BIT] & (|(mie & mip)) & ~interrupt_ack;
            if (mip[11] && mie[11])
                irq_code <= M_EXT_INT;
            else if (mip[3] && mie[3])
                irq_code <= M_SW_INT;
            else if (mip[7] && mie[7])
                irq_code <= M_TIM_INT;
        end
    end

    // Performance counters
    always_ff @(posedge clk) begin
        if (!reset) begin
            cycle   <= '0;
            instret <= '0;
        end else begin
            cycle <= cycle + 64'd1;
            if (retire)
                instret <= instret + 64'd1;
        end
    end

endmodule

//--- source/clint_timer.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module clint_timer (
    input  logic              clk,
    input  logic              reset,
    input  csr_pkg::apb_req_t bus_req,
    input  logic              psel,
    output csr_pkg::apb_rsp_t rsp,
    output logic              timer_irq,
    output logic              sw_irq
);
    import csr_pkg::*;

    localparam int DIV    = `CLINT_TICK_DIV;
    localparam int TICK_W = $clog2(DIV + 1);

    logic [63:0]       mtime;
    logic [63:0]       mtimecmp;
    logic              msip;
    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    logic              access;
    logic              wr_en;
    logic [2:0]        offset;
    logic              known;
    logic [31:0]       rd_data;

    assign access = psel & bus_req.penable;
    assign wr_en  = access & bus_req.pwrite;
    assign offset = bus_req.paddr[4:2];

    always_comb begin
        known = 1'b1;
        case (offset)
            `TMR_MTIME_LO: rd_data = mtime[31:0];
            `TMR_MTIME_HI: rd_data = mtime[63:32];
            `TMR_MTCMP_LO: rd_data = mtimecmp[31:0];
            `TMR_MTCMP_HI: rd_data = mtimecmp[63:32];
            `TMR_MSIP:     rd_data = {31'b0, msip};
            default: begin
                known   = 1'b0;
                rd_data = '0;
            end
        endcase
    end

    assign rsp.prdata  = access ? rd_data : '0;
    assign rsp.pready  = access;
    assign rsp.pslverr = access & ~known;

    // Prescaler for mtime
    assign tick = (tick_cnt == TICK_W'(DIV - 1));

    always_ff @(posedge clk) begin
        if (!reset)
            tick_cnt <= '0;
        else if (tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            mtime    <= '0;
            mtimecmp <= '1;   // Timer interrupt stays quiet
            msip     <= 1'b0;
        end else begin
            if (wr_en && offset == `TMR_MTIME_LO)
                mtime[31:0] <= bus_req.pwdata;
            else if (wr_en && offset == `TMR_MTIME_HI)
                mtime[63:32] <= bus_req.pwdata;
            else if (tick)
                mtime <= mtime + 64'd1;
            if (wr_en && offset == `TMR_MTCMP_LO)
                mtimecmp[31:0] <= bus_req.pwdata;
            if (wr_en && offset == `TMR_MTCMP_HI)
                mtimecmp[63:32] <= bus_req.pwdata;
            if (wr_en && offset == `TMR_MSIP)
                msip <= bus_req.pwdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset)
            timer_irq <= 1'b0;
        else
            timer_irq <= (mtime >= mtimecmp);
    end

    assign sw_irq = msip;

endmodule

//--- source/trap_unit_top.sv
`timescale 1ns/1ps

module trap_unit_top (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::apb_req_t  core_req,
    output csr_pkg::apb_rsp_t  core_rsp,
    input  csr_pkg::apb_req_t  dbg_req,
    output csr_pkg::apb_rsp_t  dbg_rsp,
    input  csr_pkg::trap_req_t trap,
    input  logic               interrupt_ack,
    input  logic               retire,
    input  logic               ext_irq,
    output logic               interrupt_pending,
    output csr_pkg::irq_code_e irq_code,
    output logic [31:0]        mtvec,
    output logic [31:0]        mepc
);
    import csr_pkg::*;

    apb_req_t bus_req;     // Shared bus after arbitration
    apb_rsp_t csr_rsp;
    apb_rsp_t tmr_rsp;
    logic     csr_psel;
    logic     tmr_psel;
    logic     timer_irq;
    logic     sw_irq;

    apb_arbiter apb_arbiter_inst (
        .clk      (clk),
        .reset    (reset),
        .core_req (core_req),
        .core_rsp (core_rsp),
        .dbg_req  (dbg_req),
        .dbg_rsp  (dbg_rsp),
        .bus_req  (bus_req),
        .csr_psel (csr_psel),
        .tmr_psel (tmr_psel),
        .csr_rsp  (csr_rsp),
        .tmr_rsp  (tmr_rsp)
    );

    csr_bank csr_bank_inst (
        .clk               (clk),
        .reset             (reset),
        .bus_req           (bus_req),
        .psel              (csr_psel),
        .rsp               (csr_rsp),
        .trap              (trap),
        .interrupt_ack     (interrupt_ack),
        .retire            (retire),
        .ext_irq           (ext_irq),
        .timer_irq         (timer_irq),
        .sw_irq            (sw_irq),
        .interrupt_pending (interrupt_pending),
        .irq_code          (irq_code),
        .mepc              (mepc),
        .mtvec             (mtvec)
    );

    clint_timer clint_timer_inst (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .psel      (tmr_psel),
        .rsp       (tmr_rsp),
        .timer_irq (timer_irq),
        .sw_irq    (sw_irq)
    );

endmodule

//--- testbench/tb_trap_unit.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module tb_trap_unit;
    import csr_pkg::*;

    localparam int MAX_ENTRIES  = 64;
    localparam int WATCH_CYCLES = MAX_ENTRIES * 8 + 1000;

    typedef struct packed {
        logic        master;    // 0 core, 1 debug
        logic [1:0]  op;
        logic [11:0] num;
        logic [31:0] wdata;
        logic [31:0] exp_rd;
        logic        exp_err;
    } entry_t;

    logic         clk;
    logic         reset;
    apb_req_t     core_req;
    apb_rsp_t     core_rsp;
    apb_req_t     dbg_req;
    apb_rsp_t     dbg_rsp;
    trap_req_t    trap;
    logic         interrupt_ack;
    logic         retire;
    logic         ext_irq;
    logic         interrupt_pending;
    irq_code_e    irq_code;
    logic [31:0]  mtvec;
    logic [31:0]  mepc;

    entry_t       stim_table[$];
    integer       seed = 94;
    int           value_errors = 0;
    int           other_errors = 0;
    logic [31:0]  cyc = '0;

    // Reference copies of the CSRs
    logic [31:0]  m_mstatus, m_misa, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;

    trap_unit_top trap_unit_top_inst (
        .clk               (clk),
        .reset             (reset),
        .core_req          (core_req),
        .core_rsp          (core_rsp),
        .dbg_req           (dbg_req),
        .dbg_rsp           (dbg_rsp),
        .trap              (trap),
        .interrupt_ack     (interrupt_ack),
        .retire            (retire),
        .ext_irq           (ext_irq),
        .interrupt_pending (interrupt_pending),
        .irq_code          (irq_code),
        .mtvec             (mtvec),
        .mepc              (mepc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 32'd1;   // Testbench cycle count

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCH_CYCLES);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [16:0] csr_addr(logic [1:0] op, logic [11:0] num);
        return {1'b0, op, num, 2'b00};
    endfunction

    function automatic logic [16:0] tmr_addr(logic [2:0] off);
        return {1'b1, 11'b0, off, 2'b00};
    endfunction

    // Expected read data and pslverr followed by the masked update
    function automatic void model_access(input logic [1:0] op, input logic [11:0] num,
                                         input logic [31:0] wdata,
                                         output logic [31:0] rd, output logic err);
        logic        known;
        logic        writable;
        logic [31:0] cur;
        logic [31:0] mask;
        logic [31:0] nv;
        logic [31:0] res;
        known    = 1'b1;
        writable = 1'b1;
        cur      = '0;
        mask     = '0;
        case (num)
            12'h300: begin
                cur  = m_mstatus;
                mask = `MASK_MSTATUS;
            end
            12'h301: begin
                cur  = m_misa;
                mask = `MASK_MISA;
            end
            12'h304: begin
                cur  = m_mie;
                mask = `MASK_MIE;
            end
            12'h305: begin
                cur  = m_mtvec;
                mask = `MASK_MTVEC;
            end
            12'h340: begin
                cur  = m_mscratch;
                mask = '1;
            end
            12'h341: begin
                cur  = m_mepc;
                mask = `MASK_MEPC;
            end
            12'h342: begin
                cur  = m_mcause;
                mask = '1;
            end
            12'h343: begin
                cur  = m_mtval;
                mask = '1;
            end
            12'h344, 12'hF11, 12'hF12, 12'hF13, 12'hF14, 12'hF15: writable = 1'b0;
            default: begin
                known    = 1'b0;
                writable = 1'b0;
            end
        endcase
        rd  = cur;
        err = !known || (op != 2'd0 && !writable);
        if (op != 2'd0 && known && writable) begin
            case (op)
                2'd2:    nv = cur | wdata;
                2'd3:    nv = cur & ~wdata;
                default: nv = wdata;
            endcase
            res = (cur & ~mask) | (nv & mask);
            case (num)
                12'h300: m_mstatus  = res;
                12'h301: m_misa     = res;
                12'h304: m_mie      = res;
                12'h305: m_mtvec    = res;
                12'h340: m_mscratch = res;
                12'h341: m_mepc     = res;
                12'h342: m_mcause   = res;
                default: m_mtval    = res;
            endcase
        end
    endfunction

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("error %s: got %h, expected %h", name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic drive_req(logic master, apb_req_t req);
        if (master)
            dbg_req = req;
        else
            core_req = req;
    endtask

    // One APB transfer that waits a bounded time for pready
    task automatic apb_xfer(input logic master, input logic [16:0] addr, input logic write,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output logic [31:0] lat,
                            output logic [31:0] done_cyc);
        apb_req_t    req;
        apb_rsp_t    rsp;
        logic [31:0] start;
        int          waited;
        logic        got;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = write;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(posedge clk);
        #2;
        drive_req(master, req);
        start = cyc;
        @(posedge clk);
        #2;
        req.penable = 1'b1;
        drive_req(master, req);
        got    = 1'b0;
        waited = 0;
        rdata  = '0;
        err    = 1'b1;
        while (!got && waited < 20) begin
            @(negedge clk);
            rsp = master ? dbg_rsp : core_rsp;
            if (rsp.pready) begin
                got      = 1'b1;
                rdata    = rsp.prdata;
                err      = rsp.pslverr;
            end else begin
                waited++;
            end
            done_cyc = cyc;
            @(posedge clk);
            #2;
        end
        drive_req(master, '0);
        lat = done_cyc - start;
        if (!got) begin
            $display("Transfer from master %0d to address %h never completed", master, addr);
            other_errors++;
        end
    endtask

    task automatic csr_access(logic master, logic [1:0] op, logic [11:0] num,
                              logic [31:0] wdata);
        logic [31:0] rd;
        logic [31:0] exp_rd;
        logic [31:0] lat;
        logic [31:0] done;
        logic        err;
        logic        exp_err;
        model_access(op, num, wdata, exp_rd, exp_err);
        apb_xfer(master, csr_addr(op, num), op != 2'd0, wdata, rd, err, lat, done);
        check_value($sformatf("prdata csr %h", num), rd, exp_rd);
        check_value($sformatf("pslverr csr %h", num), {31'b0, err}, {31'b0, exp_err});
    endtask

    task automatic tmr_access(logic [2:0] off, logic write, logic [31:0] wdata,
                              logic [31:0] exp_rd);
        logic [31:0] rd;
        logic [31:0] lat;
        logic [31:0] done;
        logic        err;
        apb_xfer(1'b0, tmr_addr(off), write, wdata, rd, err, lat, done);
        check_value($sformatf("prdata timer %0d", off), rd, exp_rd);
        check_value("pslverr timer", {31'b0, err}, 32'd0);
    endtask

    task automatic add_entry(logic master, logic [1:0] op, logic [11:0] num,
                             logic [31:0] wdata);
        entry_t e;
        e.master = master;
        e.op     = op;
        e.num    = num;
        e.wdata  = wdata;
        model_access(op, num, wdata, e.exp_rd, e.exp_err);
        stim_table.push_back(e);
    endtask

    task automatic pulse_trap_pc(logic is_ack, logic [31:0] pc);
        @(posedge clk);
        #2;
        trap.pc        = pc;
        trap.privilege = PRIV_M;
        if (is_ack)
            interrupt_ack = 1'b1;
        else
            trap.raise_exception = 1'b1;
        @(posedge clk);
        #2;
        interrupt_ack        = 1'b0;
        trap.raise_exception = 1'b0;
    endtask

    // Trap entry as the model sees it
    task automatic model_entry(logic [31:0] cause, logic [31:0] epc, logic [31:0] tval,
                               logic upd_tval);
        m_mcause         = cause;
        m_mepc           = epc;
        m_mstatus[12:11] = 2'b11;
        m_mstatus[7]     = m_mstatus[3];
        m_mstatus[3]     = 1'b0;
        if (upd_tval)
            m_mtval = tval;
    endtask

    task automatic run_exception(except_code_e code, logic [31:0] pc, logic [31:0] instr);
        csr_access(1'b0, CLEAR, 12'h300, 32'h80);   // MPIE low so entry must set it
        csr_access(1'b0, SET, 12'h300, 32'h8);
        trap.except_code = code;
        trap.instruction = instr;
        pulse_trap_pc(1'b0, pc);
        model_entry({1'b0, code}, (code == ECALL_FROM_MMODE) ? pc : pc + 32'd4,
                    (code == ILLEGAL_INSTRUCTION) ? instr : pc, 1'b1);
        check_value("mepc port", mepc, m_mepc);
        csr_access(1'b0, READ, 12'h342, '0);
        csr_access(1'b1, READ, 12'h341, '0);
        csr_access(1'b0, READ, 12'h343, '0);
        csr_access(1'b0, READ, 12'h300, '0);
        @(posedge clk);
        #2;
        trap.mret = 1'b1;
        @(posedge clk);
        #2;
        trap.mret    = 1'b0;
        m_mstatus[3] = m_mstatus[7];    // MIE back from MPIE
        csr_access(1'b0, READ, 12'h300, '0);
    endtask

    task automatic wait_pending(int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!interrupt_pending && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!interrupt_pending) begin
            $display("interrupt_pending never rose");
            other_errors++;
        end
    endtask

    initial begin
        logic [11:0] csr_list [8];
        entry_t      e;
        logic [31:0] rd0, rd1, lat0, lat1, d0, d1;
        logic [31:0] c0, c1, i0, i1, cd0, cd1, rnd;
        logic        err0, err1;
        int          n_ret;

        reset         = 1'b0;
        core_req      = '0;
        dbg_req       = '0;
        trap          = '0;
        interrupt_ack = 1'b0;
        retire        = 1'b0;
        ext_irq       = 1'b0;
        m_mstatus     = '0;
        m_misa        = `MISA_RESET;
        m_mie         = '0;
        m_mtvec       = '0;
        m_mscratch    = '0;
        m_mepc        = '0;
        m_mcause      = '0;
        m_mtval       = '0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b1;

        csr_list = '{12'h300, 12'h301, 12'h304, 12'h305, 12'h340, 12'h341, 12'h342, 12'h343};
        foreach (csr_list[i]) begin
            add_entry(i[0], READ, csr_list[i], '0);
            add_entry(i[0], WRITE, csr_list[i], $random(seed));
            add_entry(~i[0], SET, csr_list[i], $random(seed));
            add_entry(i[0], CLEAR, csr_list[i], $random(seed));
            add_entry(~i[0], READ, csr_list[i], '0);
        end
        add_entry(1'b0, WRITE, 12'h344, $random(seed));   // Read-only group
        add_entry(1'b1, READ, 12'h344, '0);
        add_entry(1'b1, SET, 12'hF11, $random(seed));
        add_entry(1'b0, WRITE, 12'hF14, $random(seed));
        add_entry(1'b0, READ, 12'h7C0, '0);               // Unknown CSR
        add_entry(1'b1, WRITE, 12'h7C0, $random(seed));
        add_entry(1'b0, READ, 12'h340, '0);

        foreach (stim_table[i]) begin
            e = stim_table[i];
            apb_xfer(e.master, csr_addr(e.op, e.num), e.op != 2'd0, e.wdata,
                     rd0, err0, lat0, d0);
            check_value($sformatf("prdata entry %0d", i), rd0, e.exp_rd);
            check_value($sformatf("pslverr entry %0d", i), {31'b0, err0}, {31'b0, e.exp_err});
        end

        // Exceptions and mret
        run_exception(ILLEGAL_INSTRUCTION, 32'h0000_1000, 32'hDEAD_BEEF);
        run_exception(BREAKPOINT, 32'h0000_1100, 32'h0010_0073);
        run_exception(ECALL_FROM_MMODE, 32'h0000_1200, 32'h0000_0073);

        // External interrupt pends exactly two cycles after the line
        csr_access(1'b0, WRITE, 12'h304, 32'h800);
        csr_access(1'b0, SET, 12'h300, 32'h8);
        @(posedge clk);
        #2;
        ext_irq = 1'b1;
        @(negedge clk);
        check_value("interrupt_pending", {31'b0, interrupt_pending}, 32'd0);
        @(negedge clk);
        check_value("interrupt_pending", {31'b0, interrupt_pending}, 32'd0);
        @(negedge clk);
        check_value("interrupt_pending", {31'b0, interrupt_pending}, 32'd1);
        check_value("irq_code", {1'b0, irq_code}, {1'b0, M_EXT_INT});
        pulse_trap_pc(1'b1, 32'h0000_2040);
        ext_irq = 1'b0;
        model_entry({1'b1, M_EXT_INT}, 32'h0000_2040, '0, 1'b0);
        check_value("mepc port", mepc, m_mepc);
        csr_access(1'b0, READ, 12'h342, '0);

        // Timer interrupt from mtimecmp below mtime
        csr_access(1'b0, WRITE, 12'h304, 32'h80);
        csr_access(1'b0, SET, 12'h300, 32'h8);
        tmr_access(`TMR_MTCMP_HI, 1'b1, 32'h0, 32'hFFFF_FFFF);
        tmr_access(`TMR_MTCMP_LO, 1'b1, 32'h0, 32'hFFFF_FFFF);
        wait_pending(10);
        check_value("irq_code", {1'b0, irq_code}, {1'b0, M_TIM_INT});
        pulse_trap_pc(1'b1, 32'h0000_3000);
        model_entry({1'b1, M_TIM_INT}, 32'h0000_3000, '0, 1'b0);
        check_value("mepc port", mepc, m_mepc);
        csr_access(1'b1, READ, 12'h342, '0);

        // Both masters in the same cycle
        rnd = $random(seed);
        model_access(WRITE, 12'h340, rnd, c0, err0);
        model_access(READ, 12'h305, '0, c1, err1);
        fork
            apb_xfer(1'b0, csr_addr(WRITE, 12'h340), 1'b1, rnd, rd0, err0, lat0, d0);
            apb_xfer(1'b1, csr_addr(READ, 12'h305), 1'b0, '0, rd1, err1, lat1, d1);
        join
        check_value("core prdata", rd0, c0);
        check_value("dbg prdata", rd1, c1);
        check_value("core pslverr", {31'b0, err0}, 32'd0);
        check_value("dbg pslverr", {31'b0, err1}, 32'd0);
        if (!((lat0 == 32'd1 && lat1 == 32'd3) || (lat0 == 32'd3 && lat1 == 32'd1))) begin
            $display("Contended transfers finished after %0d and %0d cycles, not 1 and 3",
                     lat0, lat1);
            other_errors++;
        end
        check_value("mtvec port", mtvec, m_mtvec);
        csr_access(1'b0, READ, 12'h340, '0);

        // Counters
        apb_xfer(1'b0, csr_addr(READ, 12'hC00), 1'b0, '0, c0, err0, lat0, cd0);
        apb_xfer(1'b1, csr_addr(READ, 12'hC02), 1'b0, '0, i0, err0, lat0, d0);
        n_ret = 0;
        repeat (9) begin
            @(posedge clk);
            #2;
            rnd    = $random(seed);
            retire = rnd[0];
            if (rnd[0])
                n_ret++;
        end
        @(posedge clk);
        #2;
        retire = 1'b0;
        apb_xfer(1'b0, csr_addr(READ, 12'hC00), 1'b0, '0, c1, err0, lat0, cd1);
        apb_xfer(1'b1, csr_addr(READ, 12'hC02), 1'b0, '0, i1, err0, lat0, d0);
        check_value("cycle delta", c1 - c0, cd1 - cd0);
        check_value("instret delta", i1 - i0, 32'(n_ret));

        $display("Done: %0d value errors, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+source
source/csr_pkg.sv
source/apb_arbiter.sv
source/csr_bank.sv
source/clint_timer.sv
source/trap_unit_top.sv
testbench/tb_trap_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the trap unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
    --top-module tb_trap_unit -o sim_trap_unit
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_trap_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
